//--- aud_player.sv
`timescale 1ns/1ps

module aud_player import audio_pkg::*; (
    input  logic     i_clk,
    input  logic     i_rst_n,
    input  logic     i_lrc,
    input  logic     i_start,
    input  logic     i_pause,
    input  logic     i_stop,
    input  addr_t    i_length,
    input  logic     i_gnt,
    input  sample_t  i_rdata,
    output mem_req_t o_req,
    output logic     o_dac_data,
    output logic     o_busy
);

    play_state_t state_q, state_d;
    addr_t       addr_q, addr_d;
    bit_cnt_t    bit_cnt_q, bit_cnt_d;
    sample_t     shift_q, shift_d;
    logic        last_bit;

    assign last_bit = (bit_cnt_q == bit_cnt_t'(SAMPLE_W - 1));

    always_comb begin
        state_d   = state_q;
        addr_d    = addr_q;
        bit_cnt_d = bit_cnt_q;
        shift_d   = shift_q;

        case (state_q)
            PLAY_IDLE: begin
                if (i_start) begin
                    state_d = PLAY_FETCH;
                    addr_d  = '0;
                end
            end
            PLAY_FETCH: begin
                if (i_gnt) begin
                    state_d = PLAY_DELAY;
                end
            end
            PLAY_DELAY: begin
                shift_d = i_rdata;                  // read data lands one cycle after grant.
                state_d = PLAY_WAIT_HIGH;
            end
            PLAY_WAIT_HIGH: begin
                if (i_lrc) begin
                    state_d = PLAY_WAIT_LOW;
                end
            end
            PLAY_WAIT_LOW: begin
                // the cycle that sees i_lrc low is the delay bit
                if (!i_lrc) begin
                    bit_cnt_d = '0;
                    state_d   = i_pause ? PLAY_PAUSE : PLAY_SHIFT;
                end
            end
            PLAY_SHIFT: begin
                shift_d   = {shift_q[SAMPLE_W-2:0], 1'b0};
                bit_cnt_d = bit_cnt_q + 1'b1;
                if (last_bit) begin
                    // a length of 0 means a full memory.
                    if (addr_q == addr_t'(i_length - 1'b1)) begin
                        state_d = PLAY_IDLE;
                    end else begin
                        addr_d  = addr_q + 1'b1;
                        state_d = PLAY_FETCH;
                    end
                end
            end
            PLAY_PAUSE: begin
                bit_cnt_d = bit_cnt_q + 1'b1;       // silent frame, sample is kept.
                if (last_bit) begin
                    state_d = PLAY_WAIT_HIGH;
                end
            end
            default: begin
                state_d = PLAY_IDLE;
            end
        endcase

        if (i_stop) begin
            state_d = PLAY_IDLE;
        end
    end

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            state_q   <= PLAY_IDLE;
            addr_q    <= '0;
            bit_cnt_q <= '0;
        end else begin
            state_q   <= state_d;
            addr_q    <= addr_d;
            bit_cnt_q <= bit_cnt_d;
        end
    end

    always_ff @(posedge i_clk) begin
        shift_q <= shift_d;
    end

    assign o_req = '{
        req:   (state_q == PLAY_FETCH),
        we:    1'b0,
        addr:  addr_q,
        wdata: '0
    };

    assign o_dac_data = (state_q == PLAY_SHIFT) && shift_q[SAMPLE_W-1];
    assign o_busy     = (state_q != PLAY_IDLE);

endmodule

//--- aud_recorder.sv
`timescale 1ns/1ps

module aud_recorder import audio_pkg::*; (
    input  logic     i_clk,
    input  logic     i_rst_n,
    input  logic     i_lrc,
    input  logic     i_adc_data,
    input  logic     i_start,
    input  logic     i_pause,
    input  logic     i_stop,
    input  logic     i_gnt,
    output mem_req_t o_req,
    output addr_t    o_count,
    output logic     o_busy
);

    rec_state_t state_q, state_d;
    addr_t      addr_q, addr_d;
    bit_cnt_t   bit_cnt_q, bit_cnt_d;
    sample_t    shift_q, shift_d;
    logic       adc_q;                              // data bit, one cycle behind the pin.

    always_comb begin
        state_d   = state_q;
        addr_d    = addr_q;
        bit_cnt_d = bit_cnt_q;
        shift_d   = shift_q;

        case (state_q)
            REC_IDLE: begin
                if (i_start) begin
                    state_d = REC_WAIT_HIGH;
                    addr_d  = '0;                   // new recording starts at 0.
                end
            end
            REC_WAIT_HIGH: begin
                if (i_lrc) begin
                    state_d = REC_WAIT_LOW;
                end
            end
            REC_WAIT_LOW: begin
                if (!i_lrc) begin
                    state_d = i_pause ? REC_PAUSE : REC_DELAY;
                end
            end
            REC_DELAY: begin
                // adc_q now holds the I2S delay bit, which is dropped
                bit_cnt_d = '0;
                state_d   = REC_SHIFT;
            end
            REC_SHIFT: begin
                shift_d   = {shift_q[SAMPLE_W-2:0], adc_q};
                bit_cnt_d = bit_cnt_q + 1'b1;
                if (bit_cnt_q == bit_cnt_t'(SAMPLE_W - 1)) begin
                    state_d = REC_WRITE;
                end
            end
            REC_WRITE: begin
                if (i_gnt) begin
                    addr_d = addr_q + 1'b1;         // wraps to 0 on a full memory.
                    if (addr_q == addr_t'(MEM_WORDS - 1)) begin
                        state_d = REC_IDLE;
                    end else begin
                        state_d = REC_WAIT_HIGH;
                    end
                end
            end
            REC_PAUSE: begin
                if (!i_pause) begin
                    state_d = REC_WAIT_HIGH;
                end
            end
            default: begin
                state_d = REC_IDLE;
            end
        endcase

        // a write already in flight is finished, any other frame is dropped.
        if (i_stop && (state_q != REC_WRITE || i_gnt)) begin
            state_d = REC_IDLE;
        end
    end

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            state_q   <= REC_IDLE;
            addr_q    <= '0;
            bit_cnt_q <= '0;
        end else begin
            state_q   <= state_d;
            addr_q    <= addr_d;
            bit_cnt_q <= bit_cnt_d;
        end
    end

    always_ff @(posedge i_clk) begin
        adc_q   <= i_adc_data;
        shift_q <= shift_d;
    end

    assign o_req = '{
        req:   (state_q == REC_WRITE),
        we:    1'b1,
        addr:  addr_q,
        wdata: shift_q
    };

    assign o_count = addr_q;                        // samples written so far.
    assign o_busy  = (state_q != REC_IDLE);

endmodule

//--- audio_assertions.sv
`timescale 1ns/1ps

module audio_assertions import audio_pkg::*; (
    input logic     i_clk,
    input logic     i_rst_n,
    input mem_req_t i_rec_req,
    input mem_req_t i_play_req,
    input logic     i_rec_gnt,
    input logic     i_play_gnt
);

    a_one_grant: assert property (@(posedge i_clk) disable iff (i_rst_n)
        !(i_rec_gnt && i_play_gnt)) else $error("both grants high");

    a_rec_gnt_req: assert property (@(posedge i_clk) disable iff (i_rst_n)
        i_rec_gnt |-> i_rec_req.req) else $error("recorder grant without req");

    a_play_gnt_req: assert property (@(posedge i_clk) disable iff (i_rst_n)
        i_play_gnt |-> i_play_req.req) else $error("player grant without req");

    // held request keeps its address and data.
    a_rec_hold: assert property (@(posedge i_clk) disable iff (i_rst_n)
        (i_rec_req.req && !i_rec_gnt) |=> (i_rec_req.req && $stable(i_rec_req)))
        else $error("recorder req changed before grant");

    a_play_hold: assert property (@(posedge i_clk) disable iff (i_rst_n)
        (i_play_req.req && !i_play_gnt) |=> (i_play_req.req && $stable(i_play_req)))
        else $error("player req changed before grant");

endmodule

bind mem_arbiter audio_assertions u_arb_assertions (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_rec_req  (i_rec_req),
    .i_play_req (i_play_req),
    .i_rec_gnt  (o_rec_gnt),
    .i_play_gnt (o_play_gnt)
);

bind aud_recorder audio_assertions u_rec_assertions (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_rec_req  (o_req),
    .i_play_req ('0),
    .i_rec_gnt  (i_gnt),
    .i_play_gnt (1'b0)
);

//--- audio_checker.sv
`timescale 1ns/1ps

module audio_checker import audio_pkg::*; (
    input logic  i_clk,
    input logic  i_rst_n,
    input logic  i_lrc,
    input logic  i_adc_data,
    input logic  i_rec_start,
    input logic  i_rec_pause,
    input logic  i_rec_stop,
    input logic  i_play_start,
    input logic  i_play_pause,
    input logic  i_play_stop,
    input logic  i_dac_data,
    input addr_t i_rec_count
);

    typedef struct packed {
        sample_t data;
        logic    paused;
        logic    dropped;
    } frame_t;

    typedef sample_t sample_q_t[$];

    int        err_cnt = 0;
    int        frames_checked = 0;
    frame_t    rec_log[$];
    sample_q_t exp_rec;
    sample_t   model_mem [0:MEM_WORDS-1];
    int        model_count = 0;
    logic      lrc_q = 1'b0;
    logic      rec_on = 1'b0;
    logic      play_on = 1'b0;
    int        rec_bits = 0;
    logic      rec_paused = 1'b0;
    sample_t   rec_shift = '0;
    int        play_bits = 0;
    logic      play_paused = 1'b0;
    sample_t   play_shift = '0;
    sample_t   play_exp = '0;
    addr_t     play_addr = '0;

    // samples that end up in memory: whole frames, not paused, not cut by a stop.
    function automatic sample_q_t expected_recording(input frame_t frames[$]);
        sample_q_t kept;
        foreach (frames[i]) begin
            if (!frames[i].paused && !frames[i].dropped) begin
                kept.push_back(frames[i].data);
            end
        end
        return kept;
    endfunction

    task automatic log_frame(input logic dropped);
        rec_log.push_back('{data: rec_shift, paused: rec_paused, dropped: dropped});
        exp_rec = expected_recording(rec_log);
        foreach (exp_rec[i]) begin
            model_mem[i] = exp_rec[i];
        end
        model_count = exp_rec.size();
    endtask

    always @(posedge i_clk) begin
        if (!i_rst_n) begin
            if (i_play_stop) begin
                play_on   = 1'b0;
                play_bits = 0;
            end
            if (i_rec_stop) begin
                if (rec_bits > 0) begin
                    log_frame(1'b1);
                end
                rec_on   = 1'b0;
                rec_bits = 0;
            end

            // playback frame is compared before this edge's recorded frame lands.
            if (play_bits > 0) begin
                play_shift = {play_shift[SAMPLE_W-2:0], i_dac_data};
                play_bits--;
                if (play_bits == 0) begin
                    frames_checked++;
                    if (play_shift !== play_exp) begin
                        err_cnt++;
                        $display("FAIL %0t: played frame %0d is %h, expected %h",
                                 $time, frames_checked, play_shift, play_exp);
                    end
                    if (!play_paused) begin
                        if (play_addr == addr_t'(model_count - 1)) begin
                            play_on = 1'b0;
                        end else begin
                            play_addr = play_addr + 1'b1;
                        end
                    end
                end
            end
            if (rec_bits > 0) begin
                rec_shift = {rec_shift[SAMPLE_W-2:0], i_adc_data};
                rec_bits--;
                if (rec_bits == 0) begin
                    log_frame(1'b0);
                end
            end

            if (i_rec_start) begin
                rec_on      = 1'b1;
                model_count = 0;
                rec_log.delete();
            end
            if (i_play_start) begin
                play_on   = 1'b1;
                play_addr = '0;
            end

            if (lrc_q && !i_lrc) begin
                if (i_rec_count !== addr_t'(model_count)) begin
                    err_cnt++;
                    $display("FAIL %0t: o_rec_count is %0d, expected %0d",
                             $time, i_rec_count, model_count);
                end
                if (rec_on) begin
                    rec_bits   = SAMPLE_W;
                    rec_paused = i_rec_pause;
                end
                if (play_on) begin
                    play_bits   = SAMPLE_W;
                    play_paused = i_play_pause;
                    play_exp    = i_play_pause ? '0 : model_mem[play_addr];
                end
            end
        end
        lrc_q = i_lrc;
    end

endmodule

//--- audio_pkg.sv
package audio_pkg;

    localparam int SAMPLE_W  = 16;
    localparam int ADDR_W    = 10;
    localparam int MEM_WORDS = 1024;                // also the recording capacity.
    localparam int BIT_CNT_W = $clog2(SAMPLE_W);

    typedef logic [SAMPLE_W-1:0]  sample_t;
    typedef logic [ADDR_W-1:0]    addr_t;
    typedef logic [BIT_CNT_W-1:0] bit_cnt_t;        // bit position inside a frame.

    typedef enum logic [2:0] {
        REC_IDLE,
        REC_WAIT_HIGH,
        REC_WAIT_LOW,
        REC_DELAY,
        REC_SHIFT,
        REC_WRITE,
        REC_PAUSE
    } rec_state_t;

    typedef enum logic [2:0] {
        PLAY_IDLE,
        PLAY_FETCH,
        PLAY_WAIT_HIGH,
        PLAY_WAIT_LOW,
        PLAY_DELAY,
        PLAY_SHIFT,
        PLAY_PAUSE
    } play_state_t;

    typedef struct packed {
        logic    req;
        logic    we;
        addr_t   addr;
        sample_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic    en;
        logic    we;
        addr_t   addr;
        sample_t wdata;
    } mem_cmd_t;

endpackage

//--- audio_top.sv
`timescale 1ns/1ps

module audio_top import audio_pkg::*; (
    input  logic  i_clk,
    input  logic  i_rst_n,
    input  logic  i_lrc,
    input  logic  i_adc_data,
    input  logic  i_rec_start,
    input  logic  i_rec_pause,
    input  logic  i_rec_stop,
    input  logic  i_play_start,
    input  logic  i_play_pause,
    input  logic  i_play_stop,
    output logic  o_dac_data,
    output logic  o_rec_busy,
    output logic  o_play_busy,
    output addr_t o_rec_count
);

    mem_req_t rec_req;
    mem_req_t play_req;
    logic     rec_gnt;
    logic     play_gnt;
    mem_cmd_t ram_cmd;
    sample_t  ram_rdata;

    aud_recorder u_recorder (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_lrc      (i_lrc),
        .i_adc_data (i_adc_data),
        .i_start    (i_rec_start),
        .i_pause    (i_rec_pause),
        .i_stop     (i_rec_stop),
        .i_gnt      (rec_gnt),
        .o_req      (rec_req),
        .o_count    (o_rec_count),
        .o_busy     (o_rec_busy)
    );

    aud_player u_player (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_lrc      (i_lrc),
        .i_start    (i_play_start),
        .i_pause    (i_play_pause),
        .i_stop     (i_play_stop),
        .i_length   (o_rec_count),                  // plays what has been recorded.
        .i_gnt      (play_gnt),
        .i_rdata    (ram_rdata),
        .o_req      (play_req),
        .o_dac_data (o_dac_data),
        .o_busy     (o_play_busy)
    );

    mem_arbiter u_arbiter (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_rec_req  (rec_req),
        .i_play_req (play_req),
        .o_rec_gnt  (rec_gnt),
        .o_play_gnt (play_gnt),
        .o_cmd      (ram_cmd)
    );

    sample_ram u_ram (
        .i_clk      (i_clk),
        .i_cmd      (ram_cmd),
        .o_rdata    (ram_rdata)
    );

endmodule

//--- flist.f
audio_pkg.sv
aud_recorder.sv
aud_player.sv
mem_arbiter.sv
sample_ram.sv
audio_top.sv
audio_checker.sv
audio_assertions.sv
tb_audio_top.sv

//--- mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter import audio_pkg::*; (
    input  logic     i_clk,
    input  logic     i_rst_n,
    input  mem_req_t i_rec_req,
    input  mem_req_t i_play_req,
    output logic     o_rec_gnt,
    output logic     o_play_gnt,
    output mem_cmd_t o_cmd
);

    logic     rec_mask_q;                           // recorder was granted last cycle.
    logic     play_mask_q;
    logic     rec_gnt;
    logic     play_gnt;
    mem_req_t sel;

    // recorder first, the player takes the port in any cycle the recorder leaves free
    assign rec_gnt  = i_rec_req.req && !rec_mask_q;
    assign play_gnt = i_play_req.req && !play_mask_q && !rec_gnt;

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            rec_mask_q  <= 1'b0;
            play_mask_q <= 1'b0;
        end else begin
            rec_mask_q  <= rec_gnt;
            play_mask_q <= play_gnt;
        end
    end

    always_comb begin
        if (rec_gnt) begin
            sel = i_rec_req;
        end else begin
            sel = i_play_req;
        end
    end

    assign o_cmd = '{
        en:    rec_gnt || play_gnt,
        we:    sel.we,
        addr:  sel.addr,
        wdata: sel.wdata
    };

    assign o_rec_gnt  = rec_gnt;
    assign o_play_gnt = play_gnt;

endmodule

//--- run.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_audio_top \
    -f flist.f -Mdir obj_dir -o sim_audio
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/sim_audio)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx ">>> PASS"; then
    exit 0
fi
echo "pass message not found"
exit 1

//--- sample_ram.sv
`timescale 1ns/1ps

module sample_ram import audio_pkg::*; (
    input  logic     i_clk,
    input  mem_cmd_t i_cmd,
    output sample_t  o_rdata
);

    sample_t mem [0:MEM_WORDS-1];

    always_ff @(posedge i_clk) begin
        if (i_cmd.en) begin
            if (i_cmd.we) begin
                mem[i_cmd.addr] <= i_cmd.wdata;
            end else begin
                o_rdata <= mem[i_cmd.addr];         // valid the cycle after the grant.
            end
        end
    end

endmodule

//--- tb_audio_top.sv
`timescale 1ns/1ps

module tb_audio_top import audio_pkg::*; ();

    localparam int LEVEL_LIMIT = 100;
    localparam int PLAY_LIMIT  = 1200;
    localparam int FRAMES_EXP  = 43;

    logic  clk = 1'b0;
    logic  rst_n = 1'b1;
    logic  lrc = 1'b1;
    logic  adc_data = 1'b0;
    logic  rec_start = 1'b0;
    logic  rec_pause = 1'b0;
    logic  rec_stop = 1'b0;
    logic  play_start = 1'b0;
    logic  play_pause = 1'b0;
    logic  play_stop = 1'b0;
    logic  dac_data;
    logic  rec_busy;
    logic  play_busy;
    addr_t rec_count;
    logic  timed_out = 1'b0;
    int    tb_errs = 0;
    int    seed_val;

    always #10 clk = ~clk;

    audio_top DUT (
        .i_clk        (clk),
        .i_rst_n      (rst_n),
        .i_lrc        (lrc),
        .i_adc_data   (adc_data),
        .i_rec_start  (rec_start),
        .i_rec_pause  (rec_pause),
        .i_rec_stop   (rec_stop),
        .i_play_start (play_start),
        .i_play_pause (play_pause),
        .i_play_stop  (play_stop),
        .o_dac_data   (dac_data),
        .o_rec_busy   (rec_busy),
        .o_play_busy  (play_busy),
        .o_rec_count  (rec_count)
    );

    audio_checker u_checker (
        .i_clk        (clk),
        .i_rst_n      (rst_n),
        .i_lrc        (lrc),
        .i_adc_data   (adc_data),
        .i_rec_start  (rec_start),
        .i_rec_pause  (rec_pause),
        .i_rec_stop   (rec_stop),
        .i_play_start (play_start),
        .i_play_pause (play_pause),
        .i_play_stop  (play_stop),
        .i_dac_data   (dac_data),
        .i_rec_count  (rec_count)
    );

    // 24 cycles high, then delay bit, 16 data bits and 7 idle bits low.
    initial begin
        sample_t data;
        seed_val = $urandom(32'h6f6aeb03);
        forever begin
            repeat (24) begin
                @(negedge clk);
                lrc      = 1'b1;
                adc_data = 1'b0;
            end
            data = sample_t'($urandom);
            @(negedge clk);
            lrc      = 1'b0;
            adc_data = 1'b0;
            for (int i = SAMPLE_W - 1; i >= 0; i--) begin
                @(negedge clk);
                adc_data = data[i];
            end
            repeat (7) begin
                @(negedge clk);
                adc_data = 1'b0;
            end
        end
    end

    task automatic wait_lrc(input logic level);
        int cycles;
        cycles = 0;
        while (!timed_out && lrc !== level) begin
            @(posedge clk);
            cycles++;
            if (cycles > LEVEL_LIMIT) begin
                timed_out = 1'b1;
                $display("timeout: frame clock never went to %0b", level);
            end
        end
    endtask

    // passes the next frame start and stops in the middle of the high half after it.
    task automatic go_mid_high(input int frames);
        repeat (frames) begin
            wait_lrc(1'b0);
            wait_lrc(1'b1);
            repeat (10) @(negedge clk);
        end
    endtask

    task automatic wait_idle(input logic watch_play);
        int cycles;
        cycles = 0;
        while (!timed_out && (watch_play ? play_busy : rec_busy)) begin
            @(posedge clk);
            cycles++;
            if (cycles > PLAY_LIMIT) begin
                timed_out = 1'b1;
                $display("timeout: %s stayed busy", watch_play ? "player" : "recorder");
            end
        end
        @(negedge clk);
    endtask

    task automatic pulse_rec_start();
        rec_start = 1'b1;
        @(negedge clk);
        rec_start = 1'b0;
    endtask

    task automatic pulse_rec_stop();
        rec_stop = 1'b1;
        @(negedge clk);
        rec_stop = 1'b0;
    endtask

    task automatic play_all();
        go_mid_high(1);
        play_start = 1'b1;
        @(negedge clk);
        play_start = 1'b0;
        wait_idle(1'b1);
    endtask

    initial begin
        repeat (4) @(negedge clk);
        rst_n = 1'b0;

        go_mid_high(1);                             // 12 frames, then playback.
        pulse_rec_start();
        go_mid_high(12);
        pulse_rec_stop();
        wait_idle(1'b0);
        play_all();

        go_mid_high(1);                             // record with two paused frames.
        pulse_rec_start();
        go_mid_high(2);
        rec_pause = 1'b1;
        go_mid_high(2);
        rec_pause = 1'b0;
        go_mid_high(4);
        pulse_rec_stop();
        wait_idle(1'b0);
        play_all();

        go_mid_high(1);                             // playback with two silent frames.
        play_start = 1'b1;
        @(negedge clk);
        play_start = 1'b0;
        go_mid_high(1);
        play_pause = 1'b1;
        go_mid_high(2);
        play_pause = 1'b0;
        wait_idle(1'b1);

        go_mid_high(1);                             // play behind a running recording.
        pulse_rec_start();
        go_mid_high(2);
        wait_lrc(1'b0);
        repeat (17) @(negedge clk);                 // first fetch meets the third write.
        play_start = 1'b1;
        @(negedge clk);
        play_start = 1'b0;
        go_mid_high(5);
        pulse_rec_stop();
        wait_idle(1'b0);
        go_mid_high(1);
        play_stop = 1'b1;
        @(negedge clk);
        play_stop = 1'b0;
        wait_idle(1'b1);
        play_all();

        go_mid_high(1);                             // stop inside the sixth frame.
        pulse_rec_start();
        go_mid_high(5);
        wait_lrc(1'b0);
        repeat (8) @(negedge clk);
        pulse_rec_stop();
        wait_idle(1'b0);
        play_all();

        repeat (4) @(negedge clk);
        if (u_checker.frames_checked != FRAMES_EXP) begin
            tb_errs++;
            $display("FAIL %0t: checker compared %0d frames, expected %0d",
                     $time, u_checker.frames_checked, FRAMES_EXP);
        end
        $display("errors: checker %0d, testbench %0d, timeout %0d",
                 u_checker.err_cnt, tb_errs, timed_out);
        if (u_checker.err_cnt == 0 && tb_errs == 0 && !timed_out) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
